//--- rtl/pci_pkg.sv
package pci_pkg;

    localparam int XLEN = 32; // Data and address width

    // RV32I major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000; // Selects SUB over ADD

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered across the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

//--- rtl/wb_if.sv
`timescale 1ns/1ps

// Wishbone classic data bus, strobe folded into cyc
interface wb_if;

    logic                     cyc;   // Transaction active
    logic                     we;    // 1 = write
    logic [pci_pkg::XLEN-1:0] addr;
    logic [pci_pkg::XLEN-1:0] wdata;
    logic [pci_pkg::XLEN-1:0] rdata; // Valid with ack
    logic                     ack;   // One-cycle completion

    modport master (
        output cyc,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport slave (
        input  cyc,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

//--- rtl/core_reset_gen.sv
`timescale 1ns/1ps

module core_reset_gen #(
    parameter int RESET_CLK_CYCLES = 8
) (
    input  logic sys_clk,
    input  logic rst_n_i,
    output logic core_rst_n_o
);

    localparam int CNT_W = $clog2(RESET_CLK_CYCLES + 1);

    logic [CNT_W-1:0] hold_cnt;

    // Assert together with system reset, release after the hold count
    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_cnt     <= '0;
            core_rst_n_o <= 1'b0;
        end else if (!core_rst_n_o) begin
            if (hold_cnt == CNT_W'(RESET_CLK_CYCLES - 1)) begin
                core_rst_n_o <= 1'b1; // Last held clock
            end
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

endmodule

//--- rtl/rv_mini_core.sv
`timescale 1ns/1ps

module rv_mini_core #(
    parameter logic [pci_pkg::XLEN-1:0] BOOT_ADDR = 32'h0000_1000
) (
    input  logic                     sys_clk,
    input  logic                     rst_n_i,      // Core reset
    output logic                     imem_cyc_o,
    output logic [pci_pkg::XLEN-1:0] imem_addr_o,
    input  logic [pci_pkg::XLEN-1:0] imem_rdata_i,
    input  logic                     imem_ack_i,
    wb_if.master                     dbus
);

    localparam logic [1:0] S_BOOT  = 2'd0;
    localparam logic [1:0] S_FETCH = 2'd1;
    localparam logic [1:0] S_EXEC  = 2'd2;
    localparam logic [1:0] S_MEM   = 2'd3;

    logic [1:0]               state;
    logic [pci_pkg::XLEN-1:0] pc;
    pci_pkg::instr_u          ir;            // Latched instruction word
    logic [pci_pkg::XLEN-1:0] rf [32];

    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic [4:0]               rd;
    logic [pci_pkg::XLEN-1:0] rs1_val;
    logic [pci_pkg::XLEN-1:0] rs2_val;

    logic [pci_pkg::XLEN-1:0] imm_i;
    logic [pci_pkg::XLEN-1:0] imm_s;
    logic [pci_pkg::XLEN-1:0] imm_b;
    logic [pci_pkg::XLEN-1:0] imm_j;
    logic [pci_pkg::XLEN-1:0] imm_u;

    logic [pci_pkg::XLEN-1:0] alu_res;
    logic [pci_pkg::XLEN-1:0] next_pc;
    logic                     alu_wb;
    logic                     is_load;
    logic                     is_store;
    logic                     rf_we;
    logic [pci_pkg::XLEN-1:0] rf_wdata;

    // Register indices sit at the same place in every format
    assign opcode = ir.r_fmt.opcode;
    assign funct3 = ir.r_fmt.funct3;
    assign funct7 = ir.r_fmt.funct7;
    assign rs1    = ir.r_fmt.rs1;
    assign rs2    = ir.r_fmt.rs2;
    assign rd     = ir.r_fmt.rd;

    assign rs1_val = (rs1 == 5'd0) ? '0 : rf[rs1]; // x0 reads zero
    assign rs2_val = (rs2 == 5'd0) ? '0 : rf[rs2];

    assign imm_i = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
    assign imm_s = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
    assign imm_b = {{19{ir.b_fmt.imm_12}}, ir.b_fmt.imm_12, ir.b_fmt.imm_11,
                    ir.b_fmt.imm_10_5, ir.b_fmt.imm_4_1, 1'b0};
    assign imm_j = {{11{ir.j_fmt.imm_20}}, ir.j_fmt.imm_20, ir.j_fmt.imm_19_12,
                    ir.j_fmt.imm_11, ir.j_fmt.imm_10_1, 1'b0};
    // Upper immediate taken as bits 31:12 of the I view
    assign imm_u = {ir.i_fmt.imm, ir.i_fmt.rs1, ir.i_fmt.funct3, 12'b0};

    assign is_load  = (opcode == pci_pkg::OP_LOAD)  && (funct3 == pci_pkg::F3_LW);
    assign is_store = (opcode == pci_pkg::OP_STORE) && (funct3 == pci_pkg::F3_SW);

    // Execute, unknown encodings fall through as no-ops
    always_comb begin
        alu_res = '0;
        alu_wb  = 1'b0;
        next_pc = pc + 32'd4;
        case (opcode)
            pci_pkg::OP_LUI: begin
                alu_res = imm_u;
                alu_wb  = 1'b1;
            end
            pci_pkg::OP_IMM: begin
                if (funct3 == pci_pkg::F3_ADD_SUB) begin
                    alu_res = rs1_val + imm_i; // ADDI
                    alu_wb  = 1'b1;
                end
            end
            pci_pkg::OP_REG: begin
                if (funct7 == pci_pkg::F7_SUB && funct3 == pci_pkg::F3_ADD_SUB) begin
                    alu_res = rs1_val - rs2_val;
                    alu_wb  = 1'b1;
                end else if (funct7 == pci_pkg::F7_BASE) begin
                    case (funct3)
                        pci_pkg::F3_ADD_SUB: begin
                            alu_res = rs1_val + rs2_val;
                            alu_wb  = 1'b1;
                        end
                        pci_pkg::F3_AND: begin
                            alu_res = rs1_val & rs2_val;
                            alu_wb  = 1'b1;
                        end
                        pci_pkg::F3_OR: begin
                            alu_res = rs1_val | rs2_val;
                            alu_wb  = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
            pci_pkg::OP_BRANCH: begin
                if ((funct3 == pci_pkg::F3_BEQ && rs1_val == rs2_val) ||
                    (funct3 == pci_pkg::F3_BNE && rs1_val != rs2_val)) begin
                    next_pc = pc + imm_b;
                end
            end
            pci_pkg::OP_JAL: begin
                alu_res = pc + 32'd4; // Link value
                alu_wb  = 1'b1;
                next_pc = pc + imm_j;
            end
            default: ;
        endcase
    end

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= S_BOOT;
            pc    <= BOOT_ADDR;
        end else begin
            case (state)
                S_BOOT:  state <= S_FETCH; // One idle cycle after release
                S_FETCH: begin
                    if (imem_ack_i) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    pc    <= next_pc;
                    state <= (is_load || is_store) ? S_MEM : S_FETCH;
                end
                default: begin
                    if (dbus.ack) begin
                        state <= S_FETCH;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == S_FETCH && imem_ack_i) begin
            ir <= imem_rdata_i;
        end
    end

    assign rf_we    = (state == S_EXEC && alu_wb) ||
                      (state == S_MEM && dbus.ack && is_load);
    assign rf_wdata = (state == S_MEM) ? dbus.rdata : alu_res;

    always_ff @(posedge sys_clk) begin
        if (rf_we && rd != 5'd0) begin
            rf[rd] <= rf_wdata;
        end
    end

    assign imem_cyc_o  = (state == S_FETCH);
    assign imem_addr_o = pc;

    // Operands hold still through MEM since ir and rf only change at its end
    assign dbus.cyc   = (state == S_MEM);
    assign dbus.we    = (state == S_MEM) && is_store;
    assign dbus.addr  = rs1_val + (is_store ? imm_s : imm_i);
    assign dbus.wdata = rs2_val;

endmodule

//--- rtl/data_bus_split.sv
`timescale 1ns/1ps

module data_bus_split #(
    parameter logic [pci_pkg::XLEN-1:0] IO_BASE = 32'hF000_0000
) (
    wb_if.slave  cpu,
    wb_if.master ext,
    wb_if.master io
);

    logic io_sel;

    // Region picked by the top address nibble
    assign io_sel = (cpu.addr[pci_pkg::XLEN-1 -: 4] == IO_BASE[pci_pkg::XLEN-1 -: 4]);

    // External memory side
    assign ext.cyc   = cpu.cyc & ~io_sel;
    assign ext.we    = cpu.we & ~io_sel;
    assign ext.addr  = cpu.addr;
    assign ext.wdata = cpu.wdata;

    // Register block side
    assign io.cyc   = cpu.cyc & io_sel;
    assign io.we    = cpu.we & io_sel;
    assign io.addr  = cpu.addr;
    assign io.wdata = cpu.wdata;

    // Response from whichever side was addressed
    assign cpu.rdata = io_sel ? io.rdata : ext.rdata;
    assign cpu.ack   = io_sel ? io.ack : ext.ack;

endmodule

//--- rtl/io_regs.sv
`timescale 1ns/1ps

module io_regs (
    input  logic                     sys_clk,
    input  logic                     rst_n_i,
    wb_if.slave                      bus,
    output logic                     done_o,
    output logic [pci_pkg::XLEN-1:0] result_o
);

    logic                     ack_q;
    logic [pci_pkg::XLEN-1:0] cycle_cnt;
    logic                     tohost_wr;

    // Word offset 0 is tohost, offset 4 the cycle counter
    assign tohost_wr = bus.cyc && ack_q && bus.we && (bus.addr[3:2] == 2'd0);

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            cycle_cnt <= '0;
            done_o    <= 1'b0;
            result_o  <= '0;
        end else begin
            ack_q     <= bus.cyc & ~ack_q; // Single-cycle ack
            cycle_cnt <= cycle_cnt + 1'b1;
            if (tohost_wr) begin
                result_o <= bus.wdata;
                done_o   <= 1'b1; // Sticky until reset
            end
        end
    end

    assign bus.ack = ack_q;

    always_comb begin
        case (bus.addr[3:2])
            2'd0:    bus.rdata = result_o;
            2'd1:    bus.rdata = cycle_cnt;
            default: bus.rdata = '0;
        endcase
    end

endmodule

//--- rtl/processorci_top.sv
`timescale 1ns/1ps

module processorci_top #(
    parameter int                       RESET_CLK_CYCLES = 8,
    parameter logic [pci_pkg::XLEN-1:0] BOOT_ADDR        = 32'h0000_1000,
    parameter logic [pci_pkg::XLEN-1:0] IO_BASE          = 32'hF000_0000
) (
    input  logic                     sys_clk,
    input  logic                     rst_n_i,

    // Instruction bus, read only
    output logic                     imem_cyc_o,
    output logic [pci_pkg::XLEN-1:0] imem_addr_o,
    input  logic [pci_pkg::XLEN-1:0] imem_rdata_i,
    input  logic                     imem_ack_i,

    // External data bus
    output logic                     dmem_cyc_o,
    output logic                     dmem_we_o,
    output logic [pci_pkg::XLEN-1:0] dmem_addr_o,
    output logic [pci_pkg::XLEN-1:0] dmem_wdata_o,
    input  logic [pci_pkg::XLEN-1:0] dmem_rdata_i,
    input  logic                     dmem_ack_i,

    output logic                     done_o,   // tohost written
    output logic [pci_pkg::XLEN-1:0] result_o
);

    logic core_rst_n;

    wb_if core_dbus ();
    wb_if ext_dbus ();
    wb_if io_bus ();

    core_reset_gen #(
        .RESET_CLK_CYCLES (RESET_CLK_CYCLES)
    ) u_core_reset_gen (
        .sys_clk          (sys_clk),
        .rst_n_i          (rst_n_i),
        .core_rst_n_o     (core_rst_n)
    );

    rv_mini_core #(
        .BOOT_ADDR        (BOOT_ADDR)
    ) u_core (
        .sys_clk          (sys_clk),
        .rst_n_i          (core_rst_n),
        .imem_cyc_o       (imem_cyc_o),
        .imem_addr_o      (imem_addr_o),
        .imem_rdata_i     (imem_rdata_i),
        .imem_ack_i       (imem_ack_i),
        .dbus             (core_dbus.master)
    );

    data_bus_split #(
        .IO_BASE          (IO_BASE)
    ) u_data_bus_split (
        .cpu              (core_dbus.slave),
        .ext              (ext_dbus.master),
        .io               (io_bus.master)
    );

    // Counter and tohost run from system reset
    io_regs u_io_regs (
        .sys_clk          (sys_clk),
        .rst_n_i          (rst_n_i),
        .bus              (io_bus.slave),
        .done_o           (done_o),
        .result_o         (result_o)
    );

    assign dmem_cyc_o     = ext_dbus.cyc;
    assign dmem_we_o      = ext_dbus.we;
    assign dmem_addr_o    = ext_dbus.addr;
    assign dmem_wdata_o   = ext_dbus.wdata;
    assign ext_dbus.rdata = dmem_rdata_i;
    assign ext_dbus.ack   = dmem_ack_i;

endmodule

//--- bench/processorci_assertions.sv
`timescale 1ns/1ps

module processorci_assertions #(
    parameter int RESET_CLK_CYCLES = 8
) (
    input logic        sys_clk,
    input logic        rst_n_i,
    input logic        imem_cyc_o,
    input logic [31:0] imem_addr_o,
    input logic        imem_ack_i,
    input logic        dmem_cyc_o,
    input logic [31:0] dmem_addr_o,
    input logic [31:0] dmem_wdata_o,
    input logic        dmem_ack_i,
    input logic        done_o
);

    int failures;
    int rel_cnt;   // Clocks since system reset release, saturating

    initial failures = 0;

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) rel_cnt <= 0;
        else if (rel_cnt < 1000) rel_cnt <= rel_cnt + 1;
    end

    cyc_hold: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        (imem_cyc_o && !imem_ack_i) |=> imem_cyc_o && $stable(imem_addr_o))
        else begin $error("imem cyc dropped or addr moved before ack"); failures++; end

    dcyc_hold: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        (dmem_cyc_o && !dmem_ack_i) |=> dmem_cyc_o && $stable(dmem_addr_o) &&
        $stable(dmem_wdata_o))
        else begin $error("dmem cyc dropped or request moved before ack"); failures++; end

    done_sticky: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        done_o |=> done_o)
        else begin $error("done fell without reset"); failures++; end

    no_early_fetch: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        imem_cyc_o |-> rel_cnt >= RESET_CLK_CYCLES)
        else begin $error("fetch during core reset hold"); failures++; end

endmodule

bind processorci_top processorci_assertions #(
    .RESET_CLK_CYCLES (RESET_CLK_CYCLES)
) u_assert (.*);

//--- bench/tb_processorci.sv
`timescale 1ns/1ps

module tb_processorci;

    localparam int          RESET_CLK_CYCLES = 8;
    localparam logic [31:0] BOOT_ADDR        = 32'h0000_1000;
    localparam logic [31:0] IO_BASE          = 32'hF000_0000;
    localparam logic [31:0] DATA_BASE        = 32'h0000_2000;
    localparam int          CLK_PERIOD       = 40;
    localparam int          NUM_TESTS        = 4;

    logic        sys_clk;
    logic        rst_n_i;
    logic        imem_cyc_o;
    logic [31:0] imem_addr_o;
    logic [31:0] imem_rdata_i;
    logic        imem_ack_i;
    logic        dmem_cyc_o;
    logic        dmem_we_o;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic [31:0] dmem_rdata_i;
    logic        dmem_ack_i;
    logic        done_o;
    logic [31:0] result_o;

    logic [31:0] mem [4096];   // Word memory, 16 KiB
    logic [31:0] prog [$];
    logic [31:0] fetch_log [$];
    logic [31:0] wr_addr_log [$];
    logic [31:0] wr_data_log [$];

    processorci_top #(
        .RESET_CLK_CYCLES (RESET_CLK_CYCLES),
        .BOOT_ADDR        (BOOT_ADDR),
        .IO_BASE          (IO_BASE)
    ) dut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // Instruction side of the memory
    initial begin
        forever begin
            @(posedge sys_clk);
            #2;
            imem_ack_i = 1'b0;
            if (imem_cyc_o) begin
                repeat ($urandom_range(3, 0)) begin
                    @(posedge sys_clk);
                    #2;
                end
                // A reset during the wait withdraws the request
                if (imem_cyc_o) begin
                    fetch_log.push_back(imem_addr_o);
                    imem_rdata_i = mem[imem_addr_o[13:2]];
                    imem_ack_i   = 1'b1;
                end
            end
        end
    end

    // Data side, logs every write
    initial begin
        forever begin
            @(posedge sys_clk);
            #2;
            dmem_ack_i = 1'b0;
            if (dmem_cyc_o) begin
                repeat ($urandom_range(3, 0)) begin
                    @(posedge sys_clk);
                    #2;
                end
                if (dmem_cyc_o) begin
                    if (dmem_we_o) begin
                        mem[dmem_addr_o[13:2]] = dmem_wdata_o;
                        wr_addr_log.push_back(dmem_addr_o);
                        wr_data_log.push_back(dmem_wdata_o);
                    end
                    dmem_rdata_i = mem[dmem_addr_o[13:2]];
                    dmem_ack_i   = 1'b1;
                end
            end
        end
    end

    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("Watchdog expired, the program never wrote tohost");
        $display("TEST FAILED");
        $fatal(1, "Timeout");
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, pci_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, pci_pkg::F3_ADD_SUB, rd, pci_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, pci_pkg::F3_LW, rd, pci_pkg::OP_LOAD};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, pci_pkg::F3_SW, imm[4:0], pci_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], pci_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, pci_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, pci_pkg::OP_LUI};
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, actual,
                     expected);
            $display("TEST FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    // Address-derived fill, then the program at the boot address
    task automatic load_program();
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 32'h5A00_0000 ^ (i << 2);
        end
        foreach (prog[i]) begin
            mem[(BOOT_ADDR >> 2) + i] = prog[i];
        end
    endtask

    // Also checks the core reset hold and the first fetch address
    task automatic apply_reset();
        int low_clks;
        rst_n_i = 1'b0;
        repeat (2) @(posedge sys_clk);
        #2;
        fetch_log.delete();
        wr_addr_log.delete();
        wr_data_log.delete();
        rst_n_i  = 1'b1;
        low_clks = 0;
        do begin
            @(posedge sys_clk);
            #1;
            if (!imem_cyc_o) low_clks++;
        end while (!imem_cyc_o && low_clks < 100);
        check_equal(low_clks, RESET_CLK_CYCLES, "clocks without fetch after reset");
        check_equal(imem_addr_o, BOOT_ADDR, "first fetch address");
    endtask

    task automatic run_until_done();
        while (done_o !== 1'b1) begin
            @(posedge sys_clk);
            #2;
        end
        @(posedge sys_clk);
        #2;
    endtask

    task automatic test_arith();
        logic [31:0] v1, v2, v3;
        v1 = {20'h12345, 12'h000};
        v2 = v1 + 32'h0000_0678;
        v3 = 32'hFFFF_FFFB;            // -5 sign extended
        prog = {enc_lui(1, 20'h12345), enc_addi(2, 1, 12'h678), enc_addi(3, 0, 12'hFFB),
                enc_r(pci_pkg::F7_BASE, 3, 2, pci_pkg::F3_ADD_SUB, 4),
                enc_r(pci_pkg::F7_SUB, 3, 2, pci_pkg::F3_ADD_SUB, 5),
                enc_r(pci_pkg::F7_BASE, 3, 2, pci_pkg::F3_AND, 6),
                enc_r(pci_pkg::F7_BASE, 3, 1, pci_pkg::F3_OR, 7),
                enc_addi(0, 0, 12'd99),
                enc_r(pci_pkg::F7_BASE, 2, 0, pci_pkg::F3_ADD_SUB, 8),
                enc_lui(10, DATA_BASE[31:12]), enc_sw(4, 10, 0), enc_sw(5, 10, 4),
                enc_sw(6, 10, 8), enc_sw(7, 10, 12), enc_sw(8, 10, 16),
                enc_lui(11, IO_BASE[31:12]), enc_sw(2, 11, 0), enc_jal(0, 0)};
        load_program();
        apply_reset();
        run_until_done();
        check_equal(mem[(DATA_BASE >> 2) + 0], v2 + v3, "ADD result");
        check_equal(mem[(DATA_BASE >> 2) + 1], v2 - v3, "SUB result");
        check_equal(mem[(DATA_BASE >> 2) + 2], v2 & v3, "AND result");
        check_equal(mem[(DATA_BASE >> 2) + 3], v1 | v3, "OR result");
        check_equal(mem[(DATA_BASE >> 2) + 4], v2, "x0 after write");
        check_equal(result_o, v2, "tohost value");
    endtask

    task automatic test_load_store();
        logic [31:0] a, b;
        a = $urandom();
        b = $urandom();
        prog = {enc_lui(10, DATA_BASE[31:12]), enc_lw(1, 10, 12'h100), enc_lw(2, 10, 12'h104),
                enc_r(pci_pkg::F7_BASE, 2, 1, pci_pkg::F3_ADD_SUB, 3), enc_sw(3, 10, 12'h108),
                enc_r(pci_pkg::F7_SUB, 2, 1, pci_pkg::F3_ADD_SUB, 4), enc_sw(4, 10, 12'h10C),
                enc_lui(11, IO_BASE[31:12]), enc_sw(3, 11, 0), enc_jal(0, 0)};
        load_program();
        mem[(DATA_BASE + 32'h100) >> 2] = a;
        mem[(DATA_BASE + 32'h104) >> 2] = b;
        apply_reset();
        run_until_done();
        check_equal(wr_addr_log.size(), 2, "external write count");
        check_equal(wr_addr_log[0], DATA_BASE + 32'h108, "first write address");
        check_equal(wr_data_log[0], a + b, "first write data");
        check_equal(wr_addr_log[1], DATA_BASE + 32'h10C, "second write address");
        check_equal(wr_data_log[1], a - b, "second write data");
    endtask

    task automatic test_control();
        logic [31:0] exp_pc [$];
        // Offsets of the instructions that must execute
        exp_pc = {'h00, 'h04, 'h08, 'h0C, 'h14, 'h18, 'h1C, 'h20, 'h28, 'h30, 'h34, 'h38,
                  'h3C, 'h40};
        prog = {enc_addi(5, 0, 0), enc_addi(1, 0, 5), enc_addi(2, 0, 5),
                enc_b(pci_pkg::F3_BEQ, 1, 2, 13'd8), enc_addi(5, 0, 1),
                enc_b(pci_pkg::F3_BNE, 1, 2, 13'd8), enc_addi(3, 0, 7),
                enc_b(pci_pkg::F3_BEQ, 1, 3, 13'd8), enc_b(pci_pkg::F3_BNE, 1, 3, 13'd8),
                enc_addi(5, 0, 3), enc_jal(6, 21'd8), enc_addi(5, 0, 2),
                enc_lui(10, DATA_BASE[31:12]), enc_sw(6, 10, 0), enc_sw(5, 10, 4),
                enc_lui(11, IO_BASE[31:12]), enc_sw(6, 11, 0), enc_jal(0, 0)};
        load_program();
        apply_reset();
        run_until_done();
        foreach (exp_pc[i]) begin
            check_equal(fetch_log[i], BOOT_ADDR + exp_pc[i], $sformatf("fetch %0d", i));
        end
        check_equal(mem[DATA_BASE >> 2], BOOT_ADDR + 32'h2C, "JAL link value");
        check_equal(mem[(DATA_BASE >> 2) + 1], 32'd0, "skipped instructions");
    endtask

    task automatic test_io();
        logic [31:0] c0, c1;
        prog = {enc_lui(11, IO_BASE[31:12]), enc_lw(1, 11, 4), enc_lw(2, 11, 4),
                enc_lui(10, DATA_BASE[31:12]), enc_sw(1, 10, 0), enc_sw(2, 10, 4),
                enc_addi(4, 0, 12'h055), enc_sw(4, 11, 0), enc_jal(0, 0)};
        load_program();
        apply_reset();
        run_until_done();
        check_equal(result_o, 32'h55, "tohost value");
        check_equal(wr_addr_log.size(), 2, "external writes, tohost excluded");
        c0 = mem[DATA_BASE >> 2];
        c1 = mem[(DATA_BASE >> 2) + 1];
        check_equal(c0 != 0, 1'b1, "cycle count nonzero");
        check_equal(c1 > c0, 1'b1, "cycle count increasing");
    endtask

    initial begin
        void'($urandom(32'hd96b));
        rst_n_i      = 1'b0;
        imem_rdata_i = '0;
        imem_ack_i   = 1'b0;
        dmem_rdata_i = '0;
        dmem_ack_i   = 1'b0;
        test_arith();
        test_load_store();
        test_control();
        test_io();
        if (dut.u_assert.failures == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("Bus protocol assertions failed");
            $display("TEST FAILED");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

//--- sources.f
rtl/pci_pkg.sv
rtl/wb_if.sv
rtl/core_reset_gen.sv
rtl/rv_mini_core.sv
rtl/data_bus_split.sv
rtl/io_regs.sv
rtl/processorci_top.sv
bench/processorci_assertions.sv
bench/tb_processorci.sv

//--- run.sh
#!/bin/sh
# Build and run the processor harness with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_processorci \
    -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    exit 0
fi
exit 1
